// ==== src/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address and data word
`define CACHE_ADDR_WIDTH 32
`define CACHE_WORD_WIDTH 32

// line and set geometry
`define CACHE_LINE_WORDS 4
`define CACHE_SETS 16

// two ways only
`define CACHE_WAYS 2

`endif

// ==== src/cache_addr_pkg.sv ====
`include "cache_params.svh"

package cache_addr_pkg;

   // field widths of a byte address
   localparam int OFFSET_WIDTH = $clog2(`CACHE_LINE_WORDS * `CACHE_WORD_WIDTH / 8);
   localparam int INDEX_WIDTH = $clog2(`CACHE_SETS);
   localparam int TAG_WIDTH = `CACHE_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
   localparam int WORD_SEL_WIDTH = $clog2(`CACHE_LINE_WORDS);

   typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
   typedef logic [TAG_WIDTH-1:0] tag_t;
   typedef logic [INDEX_WIDTH-1:0] index_t;
   typedef logic [OFFSET_WIDTH-1:0] offset_t;
   typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

   // tag in the top bits, byte offset at the bottom
   typedef struct packed {
      tag_t tag;
      index_t index;
      offset_t offset;
   } split_addr_t;

endpackage

// ==== src/cache_mem_pkg.sv ====
`include "cache_params.svh"

package cache_mem_pkg;

   typedef logic [`CACHE_WORD_WIDTH-1:0] word_t;

   // word 0 in the low bits
   typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_WIDTH-1:0] line_t;

   // line fetch request, addr is always line aligned
   typedef struct packed {
      logic ce;
      logic [`CACHE_ADDR_WIDTH-1:0] addr;
   } mem_req_t;

   // one word per valid strobe, ascending order
   typedef struct packed {
      logic valid;
      word_t data;
   } mem_rsp_t;

endpackage

// ==== src/cache_sram.sv ====
`timescale 1ns/1ns

module cache_sram
   import cache_addr_pkg::*;
#(
   parameter int WIDTH = 32,
   parameter int DEPTH_LOG2 = 4
) (
   input  logic             clk,
   input  index_t           raddr,
   input  index_t           waddr,
   input  logic             we,
   input  logic [WIDTH-1:0] wdata,
   output logic [WIDTH-1:0] rdata
);

   logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

   // read returns the old word when both ports hit the same entry
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

// ==== src/icache_lookup.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module icache_lookup
   import cache_addr_pkg::*, cache_mem_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  split_addr_t req_addr,
   input  logic        fill_en,
   input  line_t       fill_line,
   input  logic        hit_update,
   output logic        hit,
   output logic        hit_way,
   output word_t       hit_word,
   output word_t       line_word,
   output logic        victim_way
);

   tag_t way_tag [`CACHE_WAYS];
   line_t way_line [`CACHE_WAYS];
   logic way_valid [`CACHE_WAYS];
   logic way_hit [`CACHE_WAYS];
   logic [`CACHE_SETS-1:0] valid_q [`CACHE_WAYS];
   logic lru;
   logic used_way;
   word_sel_t word_sel;

   function automatic word_t pick_word(line_t l, word_sel_t sel);
      return l[sel*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
   endfunction

   assign word_sel = req_addr.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];

   for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
      logic way_we;

      assign way_we = fill_en && (victim_way == 1'(w));

      cache_sram #(.WIDTH(TAG_WIDTH), .DEPTH_LOG2(INDEX_WIDTH)) u_tag (
         .clk   (clk),
         .raddr (req_addr.index),
         .waddr (req_addr.index),
         .we    (way_we),
         .wdata (req_addr.tag),
         .rdata (way_tag[w])
      );

      cache_sram #(.WIDTH($bits(line_t)), .DEPTH_LOG2(INDEX_WIDTH)) u_data (
         .clk   (clk),
         .raddr (req_addr.index),
         .waddr (req_addr.index),
         .we    (way_we),
         .wdata (fill_line),
         .rdata (way_line[w])
      );

      // valid bit read in step with the arrays, so tag and valid match
      always_ff @(posedge clk) begin
         if (reset) begin
            valid_q[w] <= '0;
            way_valid[w] <= 1'b0;
         end else begin
            if (way_we) begin
               valid_q[w][req_addr.index] <= 1'b1;
            end
            way_valid[w] <= valid_q[w][req_addr.index];
         end
      end

      assign way_hit[w] = way_valid[w] && (way_tag[w] == req_addr.tag);
   end

   assign hit = way_hit[0] || way_hit[1];
   assign hit_way = way_hit[1];
   assign hit_word = pick_word(way_line[hit_way], word_sel);
   assign line_word = pick_word(fill_line, word_sel);

   // empty way first, then the replacement bit
   assign victim_way = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lru);

   // point away from the way just used
   assign used_way = fill_en ? victim_way : hit_way;

   cache_sram #(.WIDTH(1), .DEPTH_LOG2(INDEX_WIDTH)) u_lru (
      .clk   (clk),
      .raddr (req_addr.index),
      .waddr (req_addr.index),
      .we    (fill_en || hit_update),
      .wdata (~used_way),
      .rdata (lru)
   );

   // a line is only filled after a miss, so a set never holds one tag twice
   a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
      !(way_hit[0] && way_hit[1]))
      else $error("both ways hit tag %h in set %0d", req_addr.tag, req_addr.index);

endmodule

// ==== src/refill_buffer.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module refill_buffer
   import cache_mem_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     capture,
   input  logic     clear,
   input  mem_rsp_t rsp,
   output line_t    line,
   output logic     full
);

   localparam int CNT_WIDTH = $clog2(`CACHE_LINE_WORDS);

   logic [CNT_WIDTH-1:0] count;
   logic take;

   assign take = capture && rsp.valid;

   // count wraps to zero as the last word sets full
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         count <= '0;
         full <= 1'b0;
      end else if (take) begin
         count <= count + 1'b1;
         full <= (count == CNT_WIDTH'(`CACHE_LINE_WORDS - 1));
      end
   end

   // shift in from the top, word 0 ends at the bottom
   always_ff @(posedge clk) begin
      if (take) begin
         line <= {rsp.data, line[$bits(line_t)-1:`CACHE_WORD_WIDTH]};
      end
   end

   a_no_extra_word: assert property (@(posedge clk) disable iff (reset)
      full |-> !rsp.valid)
      else $error("memory word arrived after the line was complete");

endmodule

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl
   import cache_addr_pkg::*, cache_mem_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        ce,
   input  split_addr_t req_addr,
   input  logic        rdata_ready,
   input  logic        hit,
   input  word_t       hit_word,
   input  word_t       line_word,
   input  logic        full,
   output mem_req_t    mem_req,
   output logic        capture,
   output logic        clear,
   output logic        fill_en,
   output logic        hit_update,
   output word_t       rdata,
   output logic        rdata_valid
);

   typedef enum logic [1:0] {
      idle,
      lookup,
      refill
   } ctrl_state_t;

   ctrl_state_t state;
   ctrl_state_t next_state;
   split_addr_t line_addr;

   always_comb begin
      next_state = state;
      case (state)
         idle: begin
            if (ce) begin
               next_state = lookup;
            end
         end
         lookup: begin
            if (!hit) begin
               next_state = refill;
            end else if (rdata_ready) begin
               next_state = idle;
            end
         end
         refill: begin
            if (full && rdata_ready) begin
               next_state = idle;
            end
         end
         default: next_state = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      line_addr = req_addr;
      line_addr.offset = '0;
   end

   // request held until the last word is in
   assign mem_req.ce = (state == refill) && !full;
   assign mem_req.addr = line_addr;
   assign capture = mem_req.ce;

   assign rdata_valid = ((state == lookup) && hit) || ((state == refill) && full);
   assign rdata = (state == refill) ? line_word : hit_word;

   // array writes happen on the completing cycle only
   assign hit_update = (state == lookup) && hit && rdata_ready;
   assign fill_en = (state == refill) && full && rdata_ready;
   assign clear = fill_en;

   // the CPU keeps ce and the address until the transfer completes
   a_req_held: assert property (@(posedge clk) disable iff (reset)
      state != idle |-> ce && $stable(req_addr))
      else $error("request dropped or changed before the transfer completed");

   a_stall_stable: assert property (@(posedge clk) disable iff (reset)
      rdata_valid && !rdata_ready |=> rdata_valid && $stable(rdata))
      else $error("rdata changed under back-pressure");

   a_req_after_miss: assert property (@(posedge clk) disable iff (reset)
      $rose(mem_req.ce) |-> state == refill && $past(state == lookup && !hit))
      else $error("memory request raised outside a missed lookup");

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ns

module icache
   import cache_addr_pkg::*, cache_mem_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     ce,
   input  addr_t    addr,
   output word_t    rdata,
   output logic     rdata_valid,
   input  logic     rdata_ready,
   output mem_req_t mem_req,
   input  mem_rsp_t mem_rsp
);

   split_addr_t req_addr;
   logic hit;
   word_t hit_word;
   word_t line_word;
   line_t line;
   logic full;
   logic capture;
   logic clear;
   logic fill_en;
   logic hit_update;

   assign req_addr = split_addr_t'(addr);

   icache_ctrl u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .ce          (ce),
      .req_addr    (req_addr),
      .rdata_ready (rdata_ready),
      .hit         (hit),
      .hit_word    (hit_word),
      .line_word   (line_word),
      .full        (full),
      .mem_req     (mem_req),
      .capture     (capture),
      .clear       (clear),
      .fill_en     (fill_en),
      .hit_update  (hit_update),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

   // way numbers stay inside the lookup
   icache_lookup u_lookup (
      .clk        (clk),
      .reset      (reset),
      .req_addr   (req_addr),
      .fill_en    (fill_en),
      .fill_line  (line),
      .hit_update (hit_update),
      .hit        (hit),
      .hit_way    (),
      .hit_word   (hit_word),
      .line_word  (line_word),
      .victim_way ()
   );

   refill_buffer u_refill (
      .clk     (clk),
      .reset   (reset),
      .capture (capture),
      .clear   (clear),
      .rsp     (mem_rsp),
      .line    (line),
      .full    (full)
   );

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
   parameter int PERIOD = 100,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset released on a rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ns
`include "cache_params.svh"

module icache_tb
   import cache_addr_pkg::*, cache_mem_pkg::*;
();

   localparam int RESET_CYCLES = 3;
   localparam int MAX_DELAY = 3;
   localparam int N_STIM = 13;
   localparam int TIMEOUT_CYCLES =
      N_STIM * (`CACHE_LINE_WORDS * 4 + MAX_DELAY + 4) + RESET_CYCLES;
   // odd multiplier for the memory contents
   localparam word_t MEM_MUL = 32'h9E37_79B1;

   typedef struct packed {
      addr_t addr;
      logic exp_hit;
      int delay;
   } stim_t;

   logic clk;
   logic reset;
   logic ce;
   addr_t addr;
   word_t rdata;
   logic rdata_valid;
   logic rdata_ready;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;
   stim_t stim [N_STIM];
   int cycle_count = 0;

   clock_gen #(.PERIOD(100), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk   (clk),
      .reset (reset)
   );

   icache UUT (
      .clk         (clk),
      .reset       (reset),
      .ce          (ce),
      .addr        (addr),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .rdata_ready (rdata_ready),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp)
   );

   function automatic word_t mem_word(addr_t a);
      return a * MEM_MUL;
   endfunction

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic expect_value(input string name, input logic [31:0] actual,
         input logic [31:0] expected);
      assert (actual === expected)
      else begin
         $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
         abort_run();
      end
   endtask

   task automatic require(input logic cond, input string what);
      assert (cond)
      else begin
         $display("failure at %0t ns: %s", $time, what);
         abort_run();
      end
   endtask

   // one request held until rdata_valid and rdata_ready meet
   task automatic run_access(input stim_t s);
      int cycles;
      int stall;
      int words_taken;
      logic seen_req;
      logic started;
      logic valid_now;
      logic done;
      word_t expected;
      cycles = 0;
      stall = 0;
      words_taken = 0;
      seen_req = 1'b0;
      started = 1'b0;
      done = 1'b0;
      expected = mem_word({s.addr[`CACHE_ADDR_WIDTH-1:2], 2'b00});
      @(posedge clk);
      ce <= 1'b1;
      addr <= s.addr;
      rdata_ready <= (s.delay == 0);
      while (!done) begin
         @(negedge clk);
         cycles++;
         valid_now = rdata_valid;
         if (mem_req.ce) begin
            seen_req = 1'b1;
            require(!s.exp_hit, "memory request raised on an expected hit");
            expect_value("mem_req.addr", mem_req.addr,
               {s.addr[`CACHE_ADDR_WIDTH-1:OFFSET_WIDTH], OFFSET_WIDTH'(0)});
            if (mem_rsp.valid) begin
               words_taken++;
            end
         end
         if (s.exp_hit && cycles == 2) begin
            require(valid_now, "expected hit not answered one cycle after ce");
         end
         if (started) begin
            require(valid_now, "rdata_valid dropped before the transfer completed");
         end
         if (valid_now) begin
            require(!mem_req.ce, "memory request still high while rdata_valid is high");
            expect_value("rdata", rdata, expected);
            if (!started && !s.exp_hit) begin
               require(seen_req, "expected miss answered without a memory request");
               require(words_taken == `CACHE_LINE_WORDS,
                  $sformatf("refill took %0d memory words", words_taken));
            end
            started = 1'b1;
            if (rdata_ready) begin
               done = 1'b1;
            end else begin
               stall++;
            end
         end
         @(posedge clk);
         if (done) begin
            ce <= 1'b0;
            rdata_ready <= 1'b0;
         end else if (valid_now && stall >= s.delay) begin
            rdata_ready <= 1'b1;
         end
      end
   endtask

   // memory model with a random gap of 0 to 3 cycles before each word
   initial begin
      int word_idx;
      int gap;
      logic send;
      addr_t base;
      mem_rsp = '0;
      word_idx = 0;
      void'($urandom(46193));
      gap = $urandom_range(3, 0);
      forever begin
         @(negedge clk);
         send = 1'b0;
         base = mem_req.addr;
         if (mem_req.ce) begin
            if (mem_rsp.valid) begin
               word_idx++;
               gap = $urandom_range(3, 0);
            end else if (gap > 0) begin
               gap--;
            end
            send = (gap == 0) && (word_idx < `CACHE_LINE_WORDS);
         end else begin
            word_idx = 0;
         end
         @(posedge clk);
         mem_rsp.valid <= send;
         mem_rsp.data <= send ? mem_word(base + addr_t'(word_idx * 4)) : '0;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: table not finished after %0d cycles", cycle_count);
         $display("TEST FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   initial begin
      ce = 1'b0;
      addr = '0;
      rdata_ready = 1'b0;
      // address, hit expected, cycles with rdata_ready low
      // set 3 holds tags 0x10, 0x20, 0x30 for the replacement check
      stim = '{
         '{32'h0000_0104, 1'b0, 0},
         '{32'h0000_010C, 1'b1, 0},
         '{32'h0000_0100, 1'b1, 2},
         '{32'h0000_1030, 1'b0, 0},
         '{32'h0000_2034, 1'b0, 3},
         '{32'h0000_1038, 1'b1, 0},
         '{32'h0000_303C, 1'b0, 1},
         '{32'h0000_1030, 1'b1, 0},
         '{32'h0000_2030, 1'b0, 0},
         '{32'h0000_0108, 1'b1, 1},
         '{32'h0000_0F00, 1'b0, 2},
         '{32'h0000_0104, 1'b1, 0},
         '{32'h0000_0F0C, 1'b1, 3}
      };
      @(negedge reset);
      repeat (2) begin
         @(negedge clk);
         require(!rdata_valid, "rdata_valid high before the first request");
         require(!mem_req.ce, "memory request high before the first request");
      end
      for (int i = 0; i < N_STIM; i++) begin
         run_access(stim[i]);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+src
src/cache_addr_pkg.sv
src/cache_mem_pkg.sv
src/cache_sram.sv
src/icache_lookup.sv
src/refill_buffer.sv
src/icache_ctrl.sv
src/icache.sv
sim/clock_gen.sv
sim/icache_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not complete, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
